//--- tidc_params.svh
// TIDC width definitions
`ifndef TIDC_PARAMS_SVH
`define TIDC_PARAMS_SVH

// ==================================================
// Address and data
// ==================================================

// Physical address width
`define TIDC_ADDR_W 64

// One full cache line per beat
`define TIDC_DATA_W 512

// ==================================================
// TileLink identifiers
// ==================================================

// Source ID width, 16 IDs in the pool
`define TIDC_SRC_W 4

// Sink ID width as issued by the L2
`define TIDC_SINK_W 4

// ==================================================
// TileLink fields
// ==================================================

// Param field, carries the permission code
`define TIDC_PARAM_W 3

`endif

//--- tl_msg_pkg.sv
// TileLink message types
`include "tidc_params.svh"

package tl_msg_pkg;

    // ==================================================
    // Channel A opcodes
    // ==================================================
    typedef enum logic [2:0] {
        a_put_full_data = 3'd0,
        a_get           = 3'd4,
        a_acquire_block = 3'd6
    } a_opcode_t;

    // ==================================================
    // Channel C opcodes
    // ==================================================
    typedef enum logic [2:0] {
        c_release      = 3'd6,
        c_release_data = 3'd7
    } c_opcode_t;

    // ==================================================
    // Channel D opcodes
    // ==================================================
    typedef enum logic [2:0] {
        d_access_ack      = 3'd0,
        d_access_ack_data = 3'd1,
        d_grant           = 3'd4,
        d_grant_data      = 3'd5,
        d_release_ack     = 3'd6
    } d_opcode_t;

    // Permission code, carried through from the L1 untouched
    // (NtoB, NtoT, BtoT on acquire, TtoN, BtoN on release)
    typedef logic [`TIDC_PARAM_W-1:0] tl_param_t;

endpackage

//--- l1_side_pkg.sv
// L1 side request types
package l1_side_pkg;

    // Request kinds issued by the L1 controller
    typedef enum logic [2:0] {
        req_read_miss      = 3'd0,
        req_write_miss     = 3'd1,
        req_write_back     = 3'd2,
        req_uncached_read  = 3'd3,
        req_uncached_write = 3'd4
    } l1_req_type_t;

    // ==================================================
    // Response the FSM is currently waiting for
    // ==================================================
    typedef enum logic [1:0] {
        wait_none        = 2'd0,
        wait_grant       = 2'd1,
        wait_release_ack = 2'd2,
        wait_access_ack  = 2'd3
    } wait_kind_t;

endpackage

//--- source_id_pool.sv
// Rotating source ID pool
`include "tidc_params.svh"

module source_id_pool (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc,
    input  logic                   free,
    output logic [`TIDC_SRC_W-1:0] cur_source,
    output logic                   avail
);

    // Next ID to hand out, wraps naturally at 2**TIDC_SRC_W
    logic [`TIDC_SRC_W-1:0] next_id;
    logic                   busy;

    // ==================================================
    // Allocation counter
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_id    <= '0;
            cur_source <= '0;
        end else if (alloc) begin
            cur_source <= next_id;
            next_id    <= next_id + 1'b1;
        end
    end

    // Busy flag, one outstanding transaction at most
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (alloc) begin
            busy <= 1'b1;
        end else if (free) begin
            busy <= 1'b0;
        end
    end

    assign avail = !busy;

endmodule

//--- d_response_decoder.sv
// Channel D response decoder
`include "tidc_params.svh"

module d_response_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    d_valid,
    input  tl_msg_pkg::d_opcode_t   d_opcode,
    input  logic [`TIDC_SRC_W-1:0]  d_source,
    input  logic [`TIDC_SINK_W-1:0] d_sink,
    input  logic [`TIDC_DATA_W-1:0] d_data,
    input  logic                    d_error,
    input  l1_side_pkg::wait_kind_t wait_kind,
    input  logic [`TIDC_SRC_W-1:0]  cur_source,
    output logic                    d_match,
    output logic [`TIDC_SINK_W-1:0] match_sink,
    output logic                    data_to_l1_valid,
    output logic [`TIDC_DATA_W-1:0] data_to_l1_data,
    output logic                    data_to_l1_error
);

    logic kind_ok;
    logic has_data;

    // ==================================================
    // Beat classification
    // ==================================================
    always_comb begin
        case (wait_kind)
            l1_side_pkg::wait_grant: begin
                kind_ok = (d_opcode == tl_msg_pkg::d_grant) ||
                          (d_opcode == tl_msg_pkg::d_grant_data);
            end
            l1_side_pkg::wait_release_ack: begin
                kind_ok = (d_opcode == tl_msg_pkg::d_release_ack);
            end
            l1_side_pkg::wait_access_ack: begin
                kind_ok = (d_opcode == tl_msg_pkg::d_access_ack) ||
                          (d_opcode == tl_msg_pkg::d_access_ack_data);
            end
            default: kind_ok = 1'b0;
        endcase
    end

    // Only the outstanding source is of interest
    assign d_match    = d_valid && kind_ok && (d_source == cur_source);
    assign match_sink = d_sink;

    // Opcodes that carry a cache line
    assign has_data = (d_opcode == tl_msg_pkg::d_grant_data) ||
                      (d_opcode == tl_msg_pkg::d_access_ack_data);

    // ==================================================
    // Data return to the L1, one cycle after the beat
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_to_l1_valid <= 1'b0;
        end else begin
            data_to_l1_valid <= d_match && has_data;
        end
    end

    always_ff @(posedge clk) begin
        if (d_match && has_data) begin
            data_to_l1_data  <= d_data;
            data_to_l1_error <= d_error;
        end
    end

endmodule

//--- tl_transaction_fsm.sv
// TileLink transaction sequencer
`include "tidc_params.svh"

module tl_transaction_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      l1_request_valid,
    input  logic [`TIDC_ADDR_W-1:0]   l1_request_addr,
    input  l1_side_pkg::l1_req_type_t l1_request_type,
    input  logic [`TIDC_DATA_W-1:0]   l1_request_data,
    input  tl_msg_pkg::tl_param_t     l1_request_permissions,
    output logic                      l1_request_ready,
    input  logic                      avail,
    input  logic [`TIDC_SRC_W-1:0]    cur_source,
    input  logic                      d_match,
    input  logic [`TIDC_SINK_W-1:0]   match_sink,
    output logic                      alloc,
    output l1_side_pkg::wait_kind_t   wait_kind,
    output logic                      a_valid,
    output tl_msg_pkg::a_opcode_t     a_opcode,
    output tl_msg_pkg::tl_param_t     a_param,
    output logic [`TIDC_SRC_W-1:0]    a_source,
    output logic [`TIDC_ADDR_W-1:0]   a_address,
    output logic [`TIDC_DATA_W-1:0]   a_data,
    input  logic                      a_ready,
    output logic                      c_valid,
    output tl_msg_pkg::c_opcode_t     c_opcode,
    output tl_msg_pkg::tl_param_t     c_param,
    output logic [`TIDC_SRC_W-1:0]    c_source,
    output logic [`TIDC_ADDR_W-1:0]   c_address,
    output logic [`TIDC_DATA_W-1:0]   c_data,
    input  logic                      c_ready,
    output logic                      e_valid,
    output logic [`TIDC_SINK_W-1:0]   e_sink,
    input  logic                      e_ready
);

    typedef enum logic [2:0] {
        st_idle, st_acq_send, st_acq_wait, st_gack_send,
        st_rel_send, st_rel_wait, st_unc_send, st_unc_wait
    } state_t;

    state_t                    state;
    state_t                    next_state;
    logic                      accept;
    logic [`TIDC_ADDR_W-1:0]   pend_addr;
    logic [`TIDC_DATA_W-1:0]   pend_data;
    tl_msg_pkg::tl_param_t     pend_perm;
    l1_side_pkg::l1_req_type_t pend_type;
    logic [`TIDC_SINK_W-1:0]   grant_sink;

    // ==================================================
    // Request acceptance
    // ==================================================
    assign l1_request_ready = (state == st_idle) && avail;
    assign accept           = l1_request_valid && l1_request_ready;

    // Unknown types are swallowed without taking an ID
    assign alloc = accept && (l1_request_type inside {
        l1_side_pkg::req_read_miss, l1_side_pkg::req_write_miss,
        l1_side_pkg::req_write_back, l1_side_pkg::req_uncached_read,
        l1_side_pkg::req_uncached_write});

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_addr <= l1_request_addr;
            pend_data <= l1_request_data;
            pend_perm <= l1_request_permissions;
            pend_type <= l1_request_type;
        end
        if (d_match) begin
            grant_sink <= match_sink;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    case (l1_request_type)
                        l1_side_pkg::req_read_miss,
                        l1_side_pkg::req_write_miss:     next_state = st_acq_send;
                        l1_side_pkg::req_write_back:     next_state = st_rel_send;
                        l1_side_pkg::req_uncached_read,
                        l1_side_pkg::req_uncached_write: next_state = st_unc_send;
                        default:                         next_state = st_idle;
                    endcase
                end
            end
            st_acq_send:  if (a_ready) next_state = st_acq_wait;
            st_acq_wait:  if (d_match) next_state = st_gack_send;
            st_gack_send: if (e_ready) next_state = st_idle;
            st_rel_send:  if (c_ready) next_state = st_rel_wait;
            st_rel_wait:  if (d_match) next_state = st_idle;
            st_unc_send:  if (a_ready) next_state = st_unc_wait;
            st_unc_wait:  if (d_match) next_state = st_idle;
            default:      next_state = st_idle;
        endcase
    end

    // Tells the decoder which D opcodes are acceptable
    always_comb begin
        case (state)
            st_acq_wait: wait_kind = l1_side_pkg::wait_grant;
            st_rel_wait: wait_kind = l1_side_pkg::wait_release_ack;
            st_unc_wait: wait_kind = l1_side_pkg::wait_access_ack;
            default:     wait_kind = l1_side_pkg::wait_none;
        endcase
    end

    // ==================================================
    // Outgoing messages, built from the latched request
    // ==================================================
    assign a_valid   = (state == st_acq_send) || (state == st_unc_send);
    assign a_opcode  = (state == st_acq_send) ? tl_msg_pkg::a_acquire_block :
                       (pend_type == l1_side_pkg::req_uncached_write) ?
                       tl_msg_pkg::a_put_full_data : tl_msg_pkg::a_get;
    // Uncached accesses carry no permission
    assign a_param   = (state == st_acq_send) ? pend_perm : '0;
    assign a_source  = cur_source;
    assign a_address = pend_addr;
    assign a_data    = (a_opcode == tl_msg_pkg::a_put_full_data) ? pend_data : '0;

    assign c_valid   = (state == st_rel_send);
    assign c_opcode  = tl_msg_pkg::c_release_data;
    assign c_param   = pend_perm;
    assign c_source  = cur_source;
    assign c_address = pend_addr;
    assign c_data    = pend_data;

    assign e_valid   = (state == st_gack_send);
    assign e_sink    = grant_sink;

endmodule

//--- l1_tilelink_adapter.sv
// L1 TileLink adapter top
`include "tidc_params.svh"

module l1_tilelink_adapter (
    input  logic                      clk,
    input  logic                      rst_n,
    // Request from the L1
    input  logic                      l1_request_valid,
    input  logic [`TIDC_ADDR_W-1:0]   l1_request_addr,
    input  l1_side_pkg::l1_req_type_t l1_request_type,
    input  logic [`TIDC_DATA_W-1:0]   l1_request_data,
    input  tl_msg_pkg::tl_param_t     l1_request_permissions,
    output logic                      l1_request_ready,
    // Data back to the L1
    output logic                      data_to_l1_valid,
    output logic [`TIDC_DATA_W-1:0]   data_to_l1_data,
    output logic                      data_to_l1_error,
    // Channel A
    output logic                      a_valid,
    output tl_msg_pkg::a_opcode_t     a_opcode,
    output tl_msg_pkg::tl_param_t     a_param,
    output logic [`TIDC_SRC_W-1:0]    a_source,
    output logic [`TIDC_ADDR_W-1:0]   a_address,
    output logic [`TIDC_DATA_W-1:0]   a_data,
    input  logic                      a_ready,
    // Channel C
    output logic                      c_valid,
    output tl_msg_pkg::c_opcode_t     c_opcode,
    output tl_msg_pkg::tl_param_t     c_param,
    output logic [`TIDC_SRC_W-1:0]    c_source,
    output logic [`TIDC_ADDR_W-1:0]   c_address,
    output logic [`TIDC_DATA_W-1:0]   c_data,
    input  logic                      c_ready,
    // Channel D
    input  logic                      d_valid,
    input  tl_msg_pkg::d_opcode_t     d_opcode,
    input  logic [`TIDC_SRC_W-1:0]    d_source,
    input  logic [`TIDC_SINK_W-1:0]   d_sink,
    input  logic [`TIDC_DATA_W-1:0]   d_data,
    input  logic                      d_error,
    output logic                      d_ready,
    // Channel E
    output logic                      e_valid,
    output logic [`TIDC_SINK_W-1:0]   e_sink,
    input  logic                      e_ready
);

    logic                    alloc;
    logic                    avail;
    logic [`TIDC_SRC_W-1:0]  cur_source;
    logic                    d_match;
    logic [`TIDC_SINK_W-1:0] match_sink;
    l1_side_pkg::wait_kind_t wait_kind;

    // Responses are never back-pressured
    assign d_ready = 1'b1;

    // ==================================================
    // Source IDs
    // ==================================================
    source_id_pool u_pool (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc      (alloc),
        .free       (d_match),
        .cur_source (cur_source),
        .avail      (avail)
    );

    // ==================================================
    // Channel D decode
    // ==================================================
    d_response_decoder u_decoder (
        .clk              (clk),
        .rst_n            (rst_n),
        .d_valid          (d_valid),
        .d_opcode         (d_opcode),
        .d_source         (d_source),
        .d_sink           (d_sink),
        .d_data           (d_data),
        .d_error          (d_error),
        .wait_kind        (wait_kind),
        .cur_source       (cur_source),
        .d_match          (d_match),
        .match_sink       (match_sink),
        .data_to_l1_valid (data_to_l1_valid),
        .data_to_l1_data  (data_to_l1_data),
        .data_to_l1_error (data_to_l1_error)
    );

    // ==================================================
    // Request sequencing, channels A, C and E
    // ==================================================
    tl_transaction_fsm u_fsm (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .l1_request_valid       (l1_request_valid),
        .l1_request_addr        (l1_request_addr),
        .l1_request_type        (l1_request_type),
        .l1_request_data        (l1_request_data),
        .l1_request_permissions (l1_request_permissions),
        .l1_request_ready       (l1_request_ready),
        .avail                  (avail),
        .cur_source             (cur_source),
        .d_match                (d_match),
        .match_sink             (match_sink),
        .alloc                  (alloc),
        .wait_kind              (wait_kind),
        .a_valid                (a_valid),
        .a_opcode               (a_opcode),
        .a_param                (a_param),
        .a_source               (a_source),
        .a_address              (a_address),
        .a_data                 (a_data),
        .a_ready                (a_ready),
        .c_valid                (c_valid),
        .c_opcode               (c_opcode),
        .c_param                (c_param),
        .c_source               (c_source),
        .c_address              (c_address),
        .c_data                 (c_data),
        .c_ready                (c_ready),
        .e_valid                (e_valid),
        .e_sink                 (e_sink),
        .e_ready                (e_ready)
    );

endmodule

//--- tb_l1_tilelink_adapter.sv
// L1 TileLink adapter testbench
`include "tidc_params.svh"

module tb_l1_tilelink_adapter;

    localparam int N_TESTS   = 27;
    localparam int MAX_STALL = 7;

    typedef struct packed {
        logic [2:0]              rtype;
        logic [2:0]              perm;
        logic [`TIDC_DATA_W-1:0] rdata;
        logic [`TIDC_SRC_W-1:0]  src;
        logic [`TIDC_ADDR_W-1:0] addr;
        logic                    with_data;
        logic                    chan;
        logic [2:0]              opc;
        logic [2:0]              param;
        logic [`TIDC_SRC_W-1:0]  msrc;
        logic [`TIDC_ADDR_W-1:0] maddr;
        logic [`TIDC_DATA_W-1:0] mdata;
    } capture_t;

    logic clk;
    logic rst_n;
    logic l1_request_valid;
    logic [`TIDC_ADDR_W-1:0] l1_request_addr;
    l1_side_pkg::l1_req_type_t l1_request_type;
    logic [`TIDC_DATA_W-1:0] l1_request_data;
    tl_msg_pkg::tl_param_t l1_request_permissions;
    logic l1_request_ready;
    logic data_to_l1_valid;
    logic [`TIDC_DATA_W-1:0] data_to_l1_data;
    logic data_to_l1_error;
    logic a_valid;
    tl_msg_pkg::a_opcode_t a_opcode;
    tl_msg_pkg::tl_param_t a_param;
    logic [`TIDC_SRC_W-1:0] a_source;
    logic [`TIDC_ADDR_W-1:0] a_address;
    logic [`TIDC_DATA_W-1:0] a_data;
    logic a_ready;
    logic c_valid;
    tl_msg_pkg::c_opcode_t c_opcode;
    tl_msg_pkg::tl_param_t c_param;
    logic [`TIDC_SRC_W-1:0] c_source;
    logic [`TIDC_ADDR_W-1:0] c_address;
    logic [`TIDC_DATA_W-1:0] c_data;
    logic c_ready;
    logic d_valid;
    tl_msg_pkg::d_opcode_t d_opcode;
    logic [`TIDC_SRC_W-1:0] d_source;
    logic [`TIDC_SINK_W-1:0] d_sink;
    logic [`TIDC_DATA_W-1:0] d_data;
    logic d_error;
    logic d_ready;
    logic e_valid;
    logic [`TIDC_SINK_W-1:0] e_sink;
    logic e_ready;

    integer seed;
    int err_count;
    int failed_tests;
    int test_num;
    int pending;
    logic [`TIDC_SRC_W-1:0] exp_src;
    capture_t cap_q[$];

    l1_tilelink_adapter uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // Reference model and compare tasks
    // ==================================================
    function automatic logic ref_msg(input logic [2:0] t, input logic [2:0] perm,
                                     input logic [`TIDC_DATA_W-1:0] data,
                                     input logic with_data,
                                     output logic [2:0] opc, output logic [2:0] prm,
                                     output logic [`TIDC_DATA_W-1:0] mdata,
                                     output tl_msg_pkg::d_opcode_t resp);
        logic on_c;
        on_c  = 1'b0;
        prm   = 3'd0;
        mdata = '0;
        case (t)
            3'd0, 3'd1: begin
                opc  = 3'd6;
                prm  = perm;
                resp = with_data ? tl_msg_pkg::d_grant_data : tl_msg_pkg::d_grant;
            end
            3'd2: begin
                on_c  = 1'b1;
                opc   = 3'd7;
                prm   = perm;
                mdata = data;
                resp  = tl_msg_pkg::d_release_ack;
            end
            3'd3: begin
                opc  = 3'd4;
                resp = tl_msg_pkg::d_access_ack_data;
            end
            default: begin
                opc   = 3'd0;
                mdata = data;
                resp  = tl_msg_pkg::d_access_ack;
            end
        endcase
        return on_c;
    endfunction

    task automatic cmp_a_opcode(input string name, input tl_msg_pkg::a_opcode_t got,
                                input tl_msg_pkg::a_opcode_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic cmp_c_opcode(input string name, input tl_msg_pkg::c_opcode_t got,
                                input tl_msg_pkg::c_opcode_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic cmp_param(input string name, input tl_msg_pkg::tl_param_t got,
                             input tl_msg_pkg::tl_param_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    // Address, source, sink and single bits
    task automatic cmp_id(input string name, input logic [`TIDC_ADDR_W-1:0] got,
                          input logic [`TIDC_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic cmp_data(input string name, input logic [`TIDC_DATA_W-1:0] got,
                            input logic [`TIDC_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    // Checks each captured message against the reference
    initial begin
        capture_t c;
        logic exp_chan;
        logic [2:0] exp_opc;
        logic [2:0] exp_prm;
        logic [`TIDC_DATA_W-1:0] exp_data;
        tl_msg_pkg::d_opcode_t exp_resp;
        forever begin
            wait (pending != 0);
            c = cap_q[0];
            exp_chan = ref_msg(c.rtype, c.perm, c.rdata, c.with_data,
                               exp_opc, exp_prm, exp_data, exp_resp);
            cmp_id("channel", {63'd0, c.chan}, {63'd0, exp_chan});
            if (exp_chan) begin
                cmp_c_opcode("c_opcode", tl_msg_pkg::c_opcode_t'(c.opc),
                             tl_msg_pkg::c_opcode_t'(exp_opc));
            end else begin
                cmp_a_opcode("a_opcode", tl_msg_pkg::a_opcode_t'(c.opc),
                             tl_msg_pkg::a_opcode_t'(exp_opc));
            end
            cmp_param("param", c.param, exp_prm);
            cmp_id("source", {60'd0, c.msrc}, {60'd0, c.src});
            cmp_id("address", c.maddr, c.addr);
            cmp_data("msg_data", c.mdata, exp_data);
            void'(cap_q.pop_front());
            pending--;
        end
    end

    function automatic logic [`TIDC_DATA_W-1:0] rand_line();
        logic [`TIDC_DATA_W-1:0] v;
        for (int i = 0; i < `TIDC_DATA_W / 32; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    task automatic end_test(input string name, input int errs_before);
        test_num++;
        if (err_count == errs_before) begin
            $display("test %0d %s ok", test_num, name);
        end else begin
            $display("test %0d %s failed", test_num, name);
            failed_tests++;
        end
    endtask

    // Sends one D beat for a single cycle
    task automatic d_beat(input tl_msg_pkg::d_opcode_t opc, input logic [3:0] src,
                          input logic [3:0] snk, input logic [`TIDC_DATA_W-1:0] data,
                          input logic err);
        d_valid  = 1'b1;
        d_opcode = opc;
        d_source = src;
        d_sink   = snk;
        d_data   = data;
        d_error  = err;
        @(posedge clk);
        #1 d_valid = 1'b0;
    endtask

    // ==================================================
    // One request, played through to the return of ready
    // ==================================================
    task automatic run_request(input string name, input logic [2:0] t,
                               input logic [2:0] perm, input logic with_data);
        capture_t c;
        logic [2:0] opc;
        logic [2:0] prm;
        logic [`TIDC_DATA_W-1:0] md;
        tl_msg_pkg::d_opcode_t resp;
        tl_msg_pkg::d_opcode_t bad_opc;
        logic [31:0] r;
        logic [3:0] snk;
        logic [`TIDC_DATA_W-1:0] rsp_data;
        logic rsp_err;
        int errs;
        int pulses;
        int e_seen;
        int n;
        errs = err_count;
        c = '0;
        c.rtype = t;
        c.perm = perm;
        c.rdata = rand_line();
        c.addr = {$random(seed), $random(seed)};
        c.src = exp_src;
        c.with_data = with_data;
        void'(ref_msg(t, perm, c.rdata, with_data, opc, prm, md, resp));
        l1_request_valid       = 1'b1;
        l1_request_type        = l1_side_pkg::l1_req_type_t'(t);
        l1_request_addr        = c.addr;
        l1_request_data        = c.rdata;
        l1_request_permissions = perm;
        @(negedge clk);
        if (!l1_request_ready) begin
            $display("%s: adapter was not ready to take the request", name);
            err_count++;
        end
        @(posedge clk);
        #1 l1_request_valid = 1'b0;
        exp_src = exp_src + 4'd1;
        @(negedge clk);
        if (!a_valid && !c_valid) begin
            $display("%s: no message on A or C after the request", name);
            err_count++;
        end
        c.chan  = c_valid;
        c.opc   = c_valid ? c_opcode : a_opcode;
        c.param = c_valid ? c_param : a_param;
        c.msrc  = c_valid ? c_source : a_source;
        c.maddr = c_valid ? c_address : a_address;
        c.mdata = c_valid ? c_data : a_data;
        cap_q.push_back(c);
        pending++;
        // The held message must not move during a random stall
        r = $random(seed);
        repeat (r[2:0]) begin
            @(negedge clk);
            if (c.chan) begin
                cmp_id("c_valid held", {63'd0, c_valid}, 64'd1);
                cmp_data("c_data held", c_data, c.mdata);
                cmp_id("c_address held", c_address, c.maddr);
            end else begin
                cmp_id("a_valid held", {63'd0, a_valid}, 64'd1);
                cmp_data("a_data held", a_data, c.mdata);
                cmp_id("a_address held", a_address, c.maddr);
            end
        end
        @(posedge clk);
        #1;
        a_ready = !c.chan;
        c_ready = c.chan;
        @(posedge clk);
        #1;
        a_ready = 1'b0;
        c_ready = 1'b0;
        // Beats that must be ignored
        bad_opc = (resp == tl_msg_pkg::d_release_ack) ? tl_msg_pkg::d_access_ack :
                                                        tl_msg_pkg::d_release_ack;
        d_beat(resp, c.src + 4'd1, 4'd0, rand_line(), 1'b0);
        @(negedge clk);
        cmp_id("ready after wrong source", {63'd0, l1_request_ready}, 64'd0);
        cmp_id("pulse after wrong source", {63'd0, data_to_l1_valid}, 64'd0);
        @(posedge clk);
        #1;
        d_beat(bad_opc, c.src, 4'd0, rand_line(), 1'b0);
        @(negedge clk);
        cmp_id("ready after wrong opcode", {63'd0, l1_request_ready}, 64'd0);
        cmp_id("pulse after wrong opcode", {63'd0, data_to_l1_valid}, 64'd0);
        @(posedge clk);
        #1;
        r = $random(seed);
        snk = r[3:0];
        rsp_err = r[4];
        rsp_data = rand_line();
        d_beat(resp, c.src, snk, rsp_data, rsp_err);
        pulses = 0;
        e_seen = 0;
        n = 0;
        // The cycle after the beat is always sampled, ready may already be back
        do begin
            @(negedge clk);
            n++;
            if (data_to_l1_valid) begin
                pulses++;
                cmp_data("data_to_l1_data", data_to_l1_data, rsp_data);
                cmp_id("data_to_l1_error", {63'd0, data_to_l1_error}, {63'd0, rsp_err});
            end
            if (e_valid) begin
                e_seen++;
                cmp_id("e_sink", {60'd0, e_sink}, {60'd0, snk});
            end
        end while (!l1_request_ready && n < 10);
        if (!l1_request_ready) begin
            $display("%s: ready did not return after the response", name);
            err_count++;
        end
        cmp_id("data pulses",
               pulses, (resp == tl_msg_pkg::d_grant_data ||
                        resp == tl_msg_pkg::d_access_ack_data) ? 64'd1 : 64'd0);
        cmp_id("grant acks", e_seen,
               (resp == tl_msg_pkg::d_grant_data || resp == tl_msg_pkg::d_grant) ?
               64'd1 : 64'd0);
        wait (pending == 0);
        end_test(name, errs);
        // Next stimulus starts just after a rising edge
        @(posedge clk);
        #1;
    endtask

    // Watchdog over the whole run
    initial begin
        #(N_TESTS * (MAX_STALL + 40) * 8);
        $display("Run timed out before all tests finished");
        $display("Some tests failed");
        $finish;
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        logic [31:0] r;
        int errs;
        seed = 32'hdea;
        err_count = 0;
        failed_tests = 0;
        test_num = 0;
        pending = 0;
        exp_src = '0;
        rst_n = 1'b0;
        l1_request_valid = 1'b0;
        l1_request_addr = '0;
        l1_request_type = l1_side_pkg::req_read_miss;
        l1_request_data = '0;
        l1_request_permissions = '0;
        a_ready = 1'b0;
        c_ready = 1'b0;
        d_valid = 1'b0;
        d_opcode = tl_msg_pkg::d_access_ack;
        d_source = '0;
        d_sink = '0;
        d_data = '0;
        d_error = 1'b0;
        e_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        errs = err_count;
        cmp_id("a_valid", {63'd0, a_valid}, 64'd0);
        cmp_id("c_valid", {63'd0, c_valid}, 64'd0);
        cmp_id("e_valid", {63'd0, e_valid}, 64'd0);
        cmp_id("data_to_l1_valid", {63'd0, data_to_l1_valid}, 64'd0);
        cmp_id("l1_request_ready", {63'd0, l1_request_ready}, 64'd1);
        cmp_id("d_ready", {63'd0, d_ready}, 64'd1);
        end_test("reset", errs);
        @(posedge clk);
        #1;
        run_request("read_miss", 3'd0, 3'd0, 1'b1);
        run_request("write_miss", 3'd1, 3'd1, 1'b1);
        run_request("grant_btot", 3'd1, 3'd2, 1'b0);
        run_request("write_back", 3'd2, 3'd1, 1'b0);
        run_request("uncached_read", 3'd3, 3'd5, 1'b0);
        run_request("uncached_write", 3'd4, 3'd3, 1'b0);
        // Unknown type is swallowed and takes no ID
        errs = err_count;
        l1_request_valid = 1'b1;
        l1_request_type = l1_side_pkg::l1_req_type_t'(3'd7);
        @(negedge clk);
        cmp_id("ready for unknown", {63'd0, l1_request_ready}, 64'd1);
        @(posedge clk);
        #1 l1_request_valid = 1'b0;
        repeat (3) begin
            @(negedge clk);
            cmp_id("a_valid unknown", {63'd0, a_valid}, 64'd0);
            cmp_id("c_valid unknown", {63'd0, c_valid}, 64'd0);
            cmp_id("ready unknown", {63'd0, l1_request_ready}, 64'd1);
        end
        end_test("unknown_type", errs);
        @(posedge clk);
        #1;
        run_request("after_unknown", 3'd3, 3'd0, 1'b0);
        // Enough requests for the source ID to wrap
        for (int i = 0; i < 18; i++) begin
            r = $random(seed);
            run_request("wrap", (r[2:0] > 3'd4) ? 3'd0 : r[2:0], r[6:4], r[8]);
        end
        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_num, failed_tests, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
tl_msg_pkg.sv
l1_side_pkg.sv
source_id_pool.sv
d_response_decoder.sv
tl_transaction_fsm.sv
l1_tilelink_adapter.sv
tb_l1_tilelink_adapter.sv

//--- Makefile
# Verilator flow for the L1 TileLink adapter

VERILATOR ?= verilator
TOP       ?= tb_l1_tilelink_adapter
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
